//--- verification/chip_io_testdata.txt
// columns: op addr data exp_resp exp_data (hex); op 1 write, 2 read, 1x with B/R back-pressure
// op 3 frame: data byte, irq in frame, irq after; op 4 exit: exit flag, code; op 5 irq: data; op 0 end
05 00000000 00000000 0 00000000
04 00000000 00000000 0 00000000
01 40000008 12345678 0 00000000
02 40000008 00000000 0 12345678
02 40000004 00000000 2 00000000
01 50000000 0badf00d 3 00000000
02 50000010 00000000 3 00000000
02 40001000 00000000 3 00000000
01 41000000 0000005a 0 00000000
02 41000004 00000000 0 00000001
01 41000000 00000033 2 00000000
03 00000000 0000005a 0 00000000
02 41000004 00000000 0 00000000
01 41000008 00000001 0 00000000
05 00000000 00000001 0 00000000
01 41000000 000000a5 0 00000000
03 00000000 000000a5 0 00000001
11 40000008 deadbeef 0 00000000
12 40000008 00000000 0 deadbeef
12 40002000 00000000 3 00000000
11 00000000 12345678 3 00000000
01 40000000 00000002 0 00000000
04 00000000 00000000 0 00000001
01 40000000 000000ab 0 00000000
04 00000000 00000000 1 00000055
00 00000000 00000000 0 00000000

//--- flist.f
+incdir+rtl
rtl/axi_lite_pkg.sv
rtl/io_map_pkg.sv
rtl/io_crossbar.sv
rtl/host_mailbox.sv
rtl/uart_tx_lite.sv
rtl/chip_io_top.sv
verification/chip_io_chk.sv
verification/chip_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and pass only if the output holds the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/100ps -f flist.f \
   --top-module chip_io_tb -o chip_io_sim \
   && ./obj_dir/chip_io_sim +verilator+error+limit+100 | tee /dev/stderr | grep -q "NO ERRORS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- verification/chip_io_tb.sv
// testbench for the IO subsystem; runs the bus tests listed in the testdata file and decodes the UART line
`include "chip_io_consts.svh"

module chip_io_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_TESTS = 64;
   localparam int FIELDS    = 5;     // op, addr, data, exp_resp, exp_data
   localparam int TIMEOUT   = 200;   // cycles per wait
   localparam int IRQ_W     = `IRQ_WIDTH;

   logic                    clk = 1'b0;
   logic                    rst_n;
   axi_lite_pkg::lite_req_t io_req;
   axi_lite_pkg::lite_rsp_t io_rsp;
   logic                    txd;
   logic [IRQ_W-1:0]        irq;
   logic                    host_exit;
   logic [`DATA_WIDTH-2:0]  exit_code;

   logic [31:0] td_mem [0:FIELDS*MAX_TESTS-1];
   logic [31:0] lcg_state = 32'ha5ac359d;
   logic [9:0]  rx_q [$];   // stop bit, irq during frame, byte
   int          err_count = 0;
   bit          hung = 1'b0;

   always #4 clk = ~clk;

   chip_io_top chip_io_top_i (
      .clk_i       ( clk       ),
      .rst_n_i     ( rst_n     ),
      .io_req_i    ( io_req    ),
      .io_rsp_o    ( io_rsp    ),
      .txd_o       ( txd       ),
      .interrupt_o ( irq       ),
      .host_exit_o ( host_exit ),
      .exit_code_o ( exit_code )
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h, expected %h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
      err_count++;
      hung = 1'b1;
   endtask

   ////////////////////////////////////////
   // bus driver
   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, input bit stall,
                            output logic [31:0] resp);
      int          cnt;
      bit          done;
      logic [31:0] r;
      resp            = '1;
      io_req.aw_addr  = addr;
      io_req.aw_valid = 1'b1;
      io_req.w_data   = data;
      io_req.w_strb   = '1;
      io_req.w_valid  = 1'b1;
      cnt = 0;
      while (!(io_rsp.aw_ready && io_rsp.w_ready) && cnt < TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (cnt == TIMEOUT) begin
         report_timeout("write address and data ready");
         return;
      end
      @(negedge clk);   // handshake on the rising edge before
      io_req.aw_valid = 1'b0;
      io_req.w_valid  = 1'b0;
      done = 1'b0;
      cnt  = 0;
      while (!done && cnt < TIMEOUT) begin
         if (stall) begin
            r = lcg_next();
            io_req.b_ready = r[31:30] == 2'b00;   // random low spans
         end
         done = io_rsp.b_valid && io_req.b_ready;
         if (!done) begin
            @(negedge clk);
            cnt++;
         end
      end
      if (!done) begin
         report_timeout("write response");
         return;
      end
      resp = 32'(io_rsp.b_resp);
      @(negedge clk);
      io_req.b_ready = 1'b1;
   endtask

   task automatic bus_read(input logic [31:0] addr, input bit stall,
                           output logic [31:0] resp, output logic [31:0] data);
      int          cnt;
      bit          done;
      logic [31:0] r;
      resp            = '1;
      data            = '1;
      io_req.ar_addr  = addr;
      io_req.ar_valid = 1'b1;
      cnt = 0;
      while (!io_rsp.ar_ready && cnt < TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (cnt == TIMEOUT) begin
         report_timeout("read address ready");
         return;
      end
      @(negedge clk);
      io_req.ar_valid = 1'b0;
      done = 1'b0;
      cnt  = 0;
      while (!done && cnt < TIMEOUT) begin
         if (stall) begin
            r = lcg_next();
            io_req.r_ready = r[31:30] == 2'b00;
         end
         done = io_rsp.r_valid && io_req.r_ready;
         if (!done) begin
            @(negedge clk);
            cnt++;
         end
      end
      if (!done) begin
         report_timeout("read response");
         return;
      end
      resp = 32'(io_rsp.r_resp);
      data = io_rsp.r_data;
      @(negedge clk);
      io_req.r_ready = 1'b1;
   endtask

   task automatic wait_irq(input logic [IRQ_W-1:0] exp);
      int cnt;
      cnt = 0;
      while (irq !== exp && cnt < TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      check_value("interrupt_o", 32'(irq), 32'(exp));
   endtask

   task automatic expect_frame(input logic [7:0] exp_byte, input logic irq_busy,
                               input logic irq_idle);
      int         cnt;
      logic [9:0] frame;
      cnt = 0;
      while (rx_q.size() == 0 && cnt < TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (rx_q.size() == 0) begin
         report_timeout("UART frame");
         return;
      end
      frame = rx_q.pop_front();
      check_value("txd_o stop bit", 32'(frame[9]), 32'h1);
      check_value("interrupt_o[0] in frame", 32'(frame[8]), 32'(irq_busy));
      check_value("txd_o byte", 32'(frame[7:0]), 32'(exp_byte));
      wait_irq(IRQ_W'(irq_idle));
   endtask

   ////////////////////////////////////////
   // serial monitor sampling mid bit
   always begin
      logic [7:0] rx_byte;
      logic       irq_busy;
      @(negedge clk);
      if (rst_n && txd === 1'b0) begin
         irq_busy = irq[0];
         repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
         for (int i = 0; i < 8; i++) begin
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
            rx_byte[i] = txd;   // LSB first
         end
         repeat (`UART_CLKS_PER_BIT) @(negedge clk);
         rx_q.push_back({txd, irq_busy, rx_byte});
      end
   end

   initial begin
      int          t;
      int          errs_before;
      int          n_failed;
      int unsigned chk_fails;
      logic [31:0] op, addr, data, exp_resp, exp_data, resp, rdata;
      io_req   = '0;
      rst_n    = 1'b0;
      n_failed = 0;
      $readmemh("verification/chip_io_testdata.txt", td_mem);
      repeat (3) @(negedge clk);
      rst_n          = 1'b1;
      io_req.b_ready = 1'b1;
      io_req.r_ready = 1'b1;
      @(negedge clk);
      check_value("io_rsp_o ready/valid", 32'({io_rsp.aw_ready, io_rsp.w_ready, io_rsp.b_valid,
                                              io_rsp.ar_ready, io_rsp.r_valid}), 32'h0);
      check_value("txd_o", 32'(txd), 32'h1);
      check_value("host_exit_o", 32'(host_exit), 32'h0);
      check_value("interrupt_o", 32'(irq), 32'h0);
      $display("reset values: %s", (err_count == 0) ? "ok" : "failed");

      t = 0;
      while (!hung && t < MAX_TESTS && td_mem[FIELDS*t] != 32'h0) begin
         op          = td_mem[FIELDS*t];
         addr        = td_mem[FIELDS*t+1];
         data        = td_mem[FIELDS*t+2];
         exp_resp    = td_mem[FIELDS*t+3];
         exp_data    = td_mem[FIELDS*t+4];
         errs_before = err_count;
         case (op[3:0])
            4'h1: begin
               bus_write(addr, data, op[4], resp);
               check_value("b_resp", resp, exp_resp);
            end
            4'h2: begin
               bus_read(addr, op[4], resp, rdata);
               check_value("r_resp", resp, exp_resp);
               check_value("r_data", rdata, exp_data);
            end
            4'h3: expect_frame(data[7:0], exp_resp[0], exp_data[0]);
            4'h4: begin
               check_value("host_exit_o", 32'(host_exit), exp_resp);
               check_value("exit_code_o", 32'(exit_code), exp_data);
            end
            4'h5: wait_irq(data[IRQ_W-1:0]);
            default: begin
               $display("test %0d has an unknown operation %h", t, op);
               err_count++;
            end
         endcase
         if (err_count != errs_before) n_failed++;
         $display("test %0d (op %h, addr %h): %s", t, op, addr,
                  (err_count == errs_before) ? "ok" : "failed");
         t++;
         @(negedge clk);
      end

      chk_fails = chip_io_top_i.chip_io_chk_i.fail_count;
      $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
               t, n_failed, err_count, chk_fails);
      if (err_count == 0 && chk_fails == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- verification/chip_io_chk.sv
// AXI4-Lite protocol assertions for the IO subsystem; bound into chip_io_top
module chip_io_chk (
   input logic                    clk_i,
   input logic                    rst_n_i,
   input axi_lite_pkg::lite_req_t io_req_i,
   input axi_lite_pkg::lite_rsp_t io_rsp_i,
   input axi_lite_pkg::lite_req_t host_req_i,
   input axi_lite_pkg::lite_req_t uart_req_i
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;
   logic        host_act, uart_act;

   assign host_act = host_req_i.aw_valid || host_req_i.w_valid || host_req_i.ar_valid;
   assign uart_act = uart_req_i.aw_valid || uart_req_i.w_valid || uart_req_i.ar_valid;

   ////////////////////////////////////////
   // responses stay put until taken
   b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      io_rsp_i.b_valid && !io_req_i.b_ready |=> io_rsp_i.b_valid && $stable(io_rsp_i.b_resp))
      else begin
         fail_count++;
         $error("B response dropped or changed while b_ready was low");
      end

   r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      io_rsp_i.r_valid && !io_req_i.r_ready |=> io_rsp_i.r_valid &&
      $stable(io_rsp_i.r_data) && $stable(io_rsp_i.r_resp))
      else begin
         fail_count++;
         $error("R response dropped or changed while r_ready was low");
      end

   one_dev: assert property (@(posedge clk_i) disable iff (!rst_n_i) !(host_act && uart_act))
      else begin
         fail_count++;
         $error("both devices see a valid request");
      end

   // single outstanding transaction
   no_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (io_rsp_i.b_valid || io_rsp_i.r_valid) |-> !(io_rsp_i.aw_ready || io_rsp_i.ar_ready))
      else begin
         fail_count++;
         $error("request accepted while a response is pending");
      end

endmodule

bind chip_io_top chip_io_chk chip_io_chk_i (
   .clk_i      ( clk_i    ),
   .rst_n_i    ( rst_n_i  ),
   .io_req_i   ( io_req_i ),
   .io_rsp_i   ( io_rsp_o ),
   .host_req_i ( host_req ),
   .uart_req_i ( uart_req )
);

//--- rtl/chip_io_top.sv
// IO subsystem top wiring the AXI4-Lite master port into the crossbar, mailbox, UART and IRQ vector
`include "chip_io_consts.svh"

module chip_io_top (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  axi_lite_pkg::lite_req_t io_req_i,
   output axi_lite_pkg::lite_rsp_t io_rsp_o,
   output logic                    txd_o,
   output logic [`IRQ_WIDTH-1:0]   interrupt_o,
   output logic                    host_exit_o,
   output logic [`DATA_WIDTH-2:0]  exit_code_o
);

   axi_lite_pkg::lite_req_t host_req, uart_req;
   axi_lite_pkg::lite_rsp_t host_rsp, uart_rsp;
   logic                    uart_irq;

   ////////////////////////////////////////
   // IO crossbar
   io_crossbar io_crossbar_i (
      .clk_i      ( clk_i    ),
      .rst_n_i    ( rst_n_i  ),
      .req_i      ( io_req_i ),
      .rsp_o      ( io_rsp_o ),
      .host_req_o ( host_req ),
      .host_rsp_i ( host_rsp ),
      .uart_req_o ( uart_req ),
      .uart_rsp_i ( uart_rsp )
   );

   ////////////////////////////////////////
   // devices
   host_mailbox host_mailbox_i (
      .clk_i       ( clk_i       ),
      .rst_n_i     ( rst_n_i     ),
      .req_i       ( host_req    ),
      .rsp_o       ( host_rsp    ),
      .host_exit_o ( host_exit_o ),
      .exit_code_o ( exit_code_o )
   );

   uart_tx_lite uart_tx_lite_i (
      .clk_i   ( clk_i    ),
      .rst_n_i ( rst_n_i  ),
      .req_i   ( uart_req ),
      .rsp_o   ( uart_rsp ),
      .txd_o   ( txd_o    ),
      .irq_o   ( uart_irq )
   );

   assign interrupt_o = {{(`IRQ_WIDTH-1){1'b0}}, uart_irq};  // bit 1 reserved

endmodule

//--- rtl/uart_tx_lite.sv
// transmit-only UART on AXI4-Lite; TXDATA starts an 8N1 frame, STATUS shows busy, CTRL enables the IRQ
`include "chip_io_consts.svh"

module uart_tx_lite (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  axi_lite_pkg::lite_req_t req_i,
   output axi_lite_pkg::lite_rsp_t rsp_o,
   output logic                    txd_o,
   output logic                    irq_o
);

   localparam int FRAME_BITS = 10;  // start, 8 data, stop
   localparam int CNT_W      = $clog2(`UART_CLKS_PER_BIT + 1);

   io_map_pkg::uart_ctrl_t    ctrl_q;
   logic                      wr_acc_q, rd_acc_q, b_valid_q, r_valid_q, busy_q;
   logic                      idle, wr_fire, rd_fire, tx_start, bit_end;
   logic [FRAME_BITS-1:0]     shift_q;
   logic [3:0]                bit_cnt_q;
   logic [CNT_W-1:0]          clk_cnt_q;
   axi_lite_pkg::resp_e       b_resp_q, r_resp_q;
   logic [`DATA_WIDTH-1:0]    r_data_q;
   logic [`REG_OFS_WIDTH-1:0] wr_ofs, rd_ofs;

   assign idle     = !(wr_acc_q || rd_acc_q || b_valid_q || r_valid_q);
   assign wr_fire  = wr_acc_q && req_i.aw_valid && req_i.w_valid;
   assign rd_fire  = rd_acc_q && req_i.ar_valid;
   assign wr_ofs   = req_i.aw_addr[`REG_OFS_WIDTH-1:0];
   assign rd_ofs   = req_i.ar_addr[`REG_OFS_WIDTH-1:0];
   assign tx_start = wr_fire && wr_ofs == `TXDATA_OFS && !busy_q;  // busy writes are dropped
   assign bit_end  = clk_cnt_q == CNT_W'(`UART_CLKS_PER_BIT - 1);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_acc_q  <= 1'b0;
         rd_acc_q  <= 1'b0;
         b_valid_q <= 1'b0;
         r_valid_q <= 1'b0;
         ctrl_q    <= '0;
         busy_q    <= 1'b0;
         bit_cnt_q <= '0;
         clk_cnt_q <= '0;
      end else begin
         wr_acc_q  <= idle && req_i.aw_valid && req_i.w_valid;
         rd_acc_q  <= idle && req_i.ar_valid && !(req_i.aw_valid && req_i.w_valid);
         b_valid_q <= wr_fire || (b_valid_q && !req_i.b_ready);
         r_valid_q <= rd_fire || (r_valid_q && !req_i.r_ready);
         if (wr_fire && wr_ofs == `CTRL_OFS) ctrl_q.irq_en <= req_i.w_data[0];
         if (tx_start) begin
            busy_q    <= 1'b1;
            bit_cnt_q <= '0;
            clk_cnt_q <= '0;
         end else if (busy_q) begin
            clk_cnt_q <= bit_end ? '0 : clk_cnt_q + 1'b1;
            if (bit_end) begin
               bit_cnt_q <= bit_cnt_q + 1'b1;
               if (bit_cnt_q == 4'(FRAME_BITS - 1)) busy_q <= 1'b0;  // stop bit done
            end
         end
      end
   end

   ////////////////////////////////////////
   // shifter and response payload
   always_ff @(posedge clk_i) begin
      if (tx_start) shift_q <= {1'b1, req_i.w_data[7:0], 1'b0};
      else if (busy_q && bit_end) shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
      if (wr_fire) begin
         b_resp_q <= (tx_start || wr_ofs == `CTRL_OFS) ? axi_lite_pkg::OKAY
                                                      : axi_lite_pkg::SLVERR;
      end
      if (rd_fire) begin
         r_resp_q <= axi_lite_pkg::OKAY;
         case (rd_ofs)
            `STATUS_OFS: r_data_q <= {{(`DATA_WIDTH-1){1'b0}}, busy_q};
            `CTRL_OFS:   r_data_q <= {{(`DATA_WIDTH-1){1'b0}}, ctrl_q.irq_en};
            default: begin
               r_data_q <= '0;
               r_resp_q <= axi_lite_pkg::SLVERR;  // TXDATA is write only
            end
         endcase
      end
   end

   always_comb begin
      rsp_o.aw_ready = wr_acc_q;
      rsp_o.w_ready  = wr_acc_q;
      rsp_o.b_resp   = b_resp_q;
      rsp_o.b_valid  = b_valid_q;
      rsp_o.ar_ready = rd_acc_q;
      rsp_o.r_data   = r_data_q;
      rsp_o.r_resp   = r_resp_q;
      rsp_o.r_valid  = r_valid_q;
   end

   assign txd_o = busy_q ? shift_q[0] : 1'b1;  // line idles high
   assign irq_o = ctrl_q.irq_en && !busy_q;

endmodule

//--- rtl/host_mailbox.sv
// tohost/fromhost mailbox on AXI4-Lite; a tohost write with bit 0 set reports the test exit
`include "chip_io_consts.svh"

module host_mailbox (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  axi_lite_pkg::lite_req_t req_i,
   output axi_lite_pkg::lite_rsp_t rsp_o,
   output logic                    host_exit_o,
   output logic [`DATA_WIDTH-2:0]  exit_code_o
);

   io_map_pkg::host_word_u    tohost_q, fromhost_q, wr_word;
   logic                      wr_acc_q, rd_acc_q, b_valid_q, r_valid_q, exit_q;
   logic                      idle, wr_fire, rd_fire;
   axi_lite_pkg::resp_e       b_resp_q, r_resp_q;
   logic [`DATA_WIDTH-1:0]    r_data_q;
   logic [`REG_OFS_WIDTH-1:0] wr_ofs, rd_ofs;

   function automatic logic [`DATA_WIDTH-1:0] merge_bytes(input logic [`DATA_WIDTH-1:0] old_w,
                                                          input logic [`DATA_WIDTH-1:0] new_w,
                                                          input logic [`STRB_WIDTH-1:0] strb);
      logic [`DATA_WIDTH-1:0] res;
      res = old_w;
      for (int i = 0; i < `STRB_WIDTH; i++) begin
         if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
      end
      return res;
   endfunction

   assign idle    = !(wr_acc_q || rd_acc_q || b_valid_q || r_valid_q);
   assign wr_fire = wr_acc_q && req_i.aw_valid && req_i.w_valid;
   assign rd_fire = rd_acc_q && req_i.ar_valid;
   assign wr_ofs  = req_i.aw_addr[`REG_OFS_WIDTH-1:0];
   assign rd_ofs  = req_i.ar_addr[`REG_OFS_WIDTH-1:0];

   assign wr_word.raw = merge_bytes((wr_ofs == `TOHOST_OFS) ? tohost_q.raw : fromhost_q.raw,
                                    req_i.w_data, req_i.w_strb);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_acc_q   <= 1'b0;
         rd_acc_q   <= 1'b0;
         b_valid_q  <= 1'b0;
         r_valid_q  <= 1'b0;
         exit_q     <= 1'b0;
         tohost_q   <= '0;
         fromhost_q <= '0;
      end else begin
         wr_acc_q  <= idle && req_i.aw_valid && req_i.w_valid;
         rd_acc_q  <= idle && req_i.ar_valid && !(req_i.aw_valid && req_i.w_valid);
         b_valid_q <= wr_fire || (b_valid_q && !req_i.b_ready);
         r_valid_q <= rd_fire || (r_valid_q && !req_i.r_ready);
         if (wr_fire && wr_ofs == `TOHOST_OFS) begin
            tohost_q <= wr_word;
            if (wr_word.exit_view.done) exit_q <= 1'b1;  // sticky
         end
         if (wr_fire && wr_ofs == `FROMHOST_OFS) fromhost_q <= wr_word;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_fire) begin
         b_resp_q <= (wr_ofs == `TOHOST_OFS || wr_ofs == `FROMHOST_OFS) ?
                     axi_lite_pkg::OKAY : axi_lite_pkg::SLVERR;
      end
      if (rd_fire) begin
         r_resp_q <= axi_lite_pkg::OKAY;
         case (rd_ofs)
            `TOHOST_OFS:   r_data_q <= tohost_q.raw;
            `FROMHOST_OFS: r_data_q <= fromhost_q.raw;
            default: begin
               r_data_q <= '0;
               r_resp_q <= axi_lite_pkg::SLVERR;
            end
         endcase
      end
   end

   always_comb begin
      rsp_o.aw_ready = wr_acc_q;
      rsp_o.w_ready  = wr_acc_q;
      rsp_o.b_resp   = b_resp_q;
      rsp_o.b_valid  = b_valid_q;
      rsp_o.ar_ready = rd_acc_q;
      rsp_o.r_data   = r_data_q;
      rsp_o.r_resp   = r_resp_q;
      rsp_o.r_valid  = r_valid_q;
   end

   assign host_exit_o = exit_q;
   assign exit_code_o = tohost_q.exit_view.code;

endmodule

//--- rtl/io_crossbar.sv
// single-master AXI4-Lite IO crossbar with one outstanding transaction; routes by the device map
`include "chip_io_consts.svh"

module io_crossbar (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  axi_lite_pkg::lite_req_t req_i,
   output axi_lite_pkg::lite_rsp_t rsp_o,
   output axi_lite_pkg::lite_req_t host_req_o,
   input  axi_lite_pkg::lite_rsp_t host_rsp_i,
   output axi_lite_pkg::lite_req_t uart_req_o,
   input  axi_lite_pkg::lite_rsp_t uart_rsp_i
);

   typedef enum logic [1:0] {ST_IDLE, ST_ACCEPT, ST_FWD, ST_RESP} state_e;

   state_e                  state_q;
   io_map_pkg::dev_sel_e    sel_q, sel_d;
   logic                    is_write_q;
   axi_lite_pkg::lite_req_t req_q;    // accepted request payload
   axi_lite_pkg::lite_req_t fwd;
   axi_lite_pkg::lite_rsp_t dev_rsp;
   logic                    wr_seen, rd_seen, dev_acc, rsp_done;

   function automatic io_map_pkg::dev_sel_e decode(input logic [`ADDR_WIDTH-1:0] addr);
      if ((addr & `HOST_MASK) == `HOST_BASE) return io_map_pkg::HOST;
      if ((addr & `UART_MASK) == `UART_BASE) return io_map_pkg::UART;
      return io_map_pkg::NONE;
   endfunction

   assign wr_seen = req_i.aw_valid && req_i.w_valid;  // write wins over read
   assign rd_seen = req_i.ar_valid;
   assign sel_d   = decode(wr_seen ? req_i.aw_addr : req_i.ar_addr);

   ////////////////////////////////////////
   // response source with local answer for unmapped
   always_comb begin
      case (sel_q)
         io_map_pkg::HOST: dev_rsp = host_rsp_i;
         io_map_pkg::UART: dev_rsp = uart_rsp_i;
         default: begin
            dev_rsp          = '0;
            dev_rsp.aw_ready = 1'b1;
            dev_rsp.w_ready  = 1'b1;
            dev_rsp.ar_ready = 1'b1;
            dev_rsp.b_resp   = axi_lite_pkg::DECERR;
            dev_rsp.b_valid  = is_write_q;
            dev_rsp.r_resp   = axi_lite_pkg::DECERR;
            dev_rsp.r_valid  = !is_write_q;   // r_data stays zero
         end
      endcase
   end

   assign dev_acc  = is_write_q ? (dev_rsp.aw_ready && dev_rsp.w_ready) : dev_rsp.ar_ready;
   assign rsp_done = is_write_q ? (dev_rsp.b_valid && req_i.b_ready)
                                : (dev_rsp.r_valid && req_i.r_ready);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= ST_IDLE;
         sel_q      <= io_map_pkg::NONE;
         is_write_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (wr_seen || rd_seen) begin
                  state_q    <= ST_ACCEPT;
                  sel_q      <= sel_d;
                  is_write_q <= wr_seen;
               end
            end
            ST_ACCEPT: state_q <= ST_FWD;
            ST_FWD:    if (dev_acc) state_q <= ST_RESP;
            ST_RESP:   if (rsp_done) state_q <= ST_IDLE;
            default:   state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == ST_IDLE && (wr_seen || rd_seen))
         req_q <= req_i;
   end

   ////////////////////////////////////////
   // master port
   always_comb begin
      rsp_o          = dev_rsp;
      rsp_o.aw_ready = (state_q == ST_ACCEPT) && is_write_q;
      rsp_o.w_ready  = (state_q == ST_ACCEPT) && is_write_q;
      rsp_o.ar_ready = (state_q == ST_ACCEPT) && !is_write_q;
      rsp_o.b_valid  = (state_q == ST_RESP) && is_write_q && dev_rsp.b_valid;
      rsp_o.r_valid  = (state_q == ST_RESP) && !is_write_q && dev_rsp.r_valid;
   end

   // only the selected device port sees traffic
   always_comb begin
      fwd          = req_q;
      fwd.aw_valid = (state_q == ST_FWD) && is_write_q;
      fwd.w_valid  = (state_q == ST_FWD) && is_write_q;
      fwd.ar_valid = (state_q == ST_FWD) && !is_write_q;
      fwd.b_ready  = (state_q == ST_RESP) && req_i.b_ready;
      fwd.r_ready  = (state_q == ST_RESP) && req_i.r_ready;
   end

   assign host_req_o = (sel_q == io_map_pkg::HOST) ? fwd : '0;
   assign uart_req_o = (sel_q == io_map_pkg::UART) ? fwd : '0;

endmodule

//--- rtl/io_map_pkg.sv
// IO device selection and device register types, used by the crossbar and the two devices
`include "chip_io_consts.svh"

package io_map_pkg;

   // crossbar target
   typedef enum logic [1:0] {
      HOST = 2'd0,
      UART = 2'd1,
      NONE = 2'd2
   } dev_sel_e;

   // UART control register
   typedef struct packed {
      logic irq_en;
   } uart_ctrl_t;

   ////////////////////////////////////////
   // mailbox word as plain word or exit report
   typedef struct packed {
      logic [`DATA_WIDTH-2:0] code;
      logic                   done;  // bit 0
   } host_exit_t;

   typedef union packed {
      logic [`DATA_WIDTH-1:0] raw;
      host_exit_t             exit_view;
   } host_word_u;

endpackage

//--- rtl/axi_lite_pkg.sv
// AXI4-Lite channel bundles for the IO bus, shared by the crossbar, the devices and the testbench
`include "chip_io_consts.svh"

package axi_lite_pkg;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } resp_e;

   ////////////////////////////////////////
   // master side
   typedef struct packed {
      logic [`ADDR_WIDTH-1:0] aw_addr;
      logic                   aw_valid;
      logic [`DATA_WIDTH-1:0] w_data;
      logic [`STRB_WIDTH-1:0] w_strb;
      logic                   w_valid;
      logic                   b_ready;
      logic [`ADDR_WIDTH-1:0] ar_addr;
      logic                   ar_valid;
      logic                   r_ready;
   } lite_req_t;

   ////////////////////////////////////////
   // slave side
   typedef struct packed {
      logic                   aw_ready;
      logic                   w_ready;
      resp_e                  b_resp;
      logic                   b_valid;
      logic                   ar_ready;
      logic [`DATA_WIDTH-1:0] r_data;
      resp_e                  r_resp;
      logic                   r_valid;
   } lite_rsp_t;

endpackage

//--- rtl/chip_io_consts.svh
// bus widths, IO device map, UART bit timing and IRQ width; include in RTL and testbench
`ifndef CHIP_IO_CONSTS_SVH
`define CHIP_IO_CONSTS_SVH

`define ADDR_WIDTH        32
`define DATA_WIDTH        32
`define STRB_WIDTH        (`DATA_WIDTH/8)

// device map with masks keeping the upper 20 address bits
`define HOST_BASE         32'h4000_0000
`define HOST_MASK         32'hFFFF_F000
`define UART_BASE         32'h4100_0000
`define UART_MASK         32'hFFFF_F000

// register offsets inside a window
`define REG_OFS_WIDTH     12
`define TOHOST_OFS        12'h000
`define FROMHOST_OFS      12'h008
`define TXDATA_OFS        12'h000
`define STATUS_OFS        12'h004
`define CTRL_OFS          12'h008

`define UART_CLKS_PER_BIT 4
`define IRQ_WIDTH         2

`endif
